// File: design/pi1_pkg.sv
`default_nettype none

package pi1_pkg;

	// Bus widths, 32-bit data with word addressing
	localparam int DATA_W = 32;
	localparam int ADDR_W = 30;
	localparam int SEL_W = DATA_W / 8;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [SEL_W-1:0] sel_t;

	// Read-write returns the old word and stores the new one
	typedef enum logic [1:0] {
		OP_NONE  = 2'b00,
		OP_WRITE = 2'b01,
		OP_READ  = 2'b10,
		OP_RDWR  = 2'b11
	} op_t;

	// Bit 0 is rst0, bit 1 is rst1
	typedef logic [1:0] rst_req_t;
	localparam rst_req_t RST_REQ_NONE = 2'b00;
	localparam rst_req_t RST_REQ_PWROFF = 2'b01;
	localparam rst_req_t RST_REQ_WARM = 2'b10;
	localparam rst_req_t RST_REQ_COLD = 2'b11;

	function automatic logic op_reads(input op_t op);
		return (op == OP_READ) || (op == OP_RDWR);
	endfunction

	function automatic logic op_writes(input op_t op);
		return (op == OP_WRITE) || (op == OP_RDWR);
	endfunction

endpackage

`default_nettype wire

// File: design/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

	// Device indices, also the order of the address map
	typedef logic [1:0] dev_idx_t;
	localparam dev_idx_t DEV_DEVTBL = 2'd0;
	localparam dev_idx_t DEV_INTCTRL = 2'd1;
	localparam dev_idx_t DEV_RAM = 2'd2;
	localparam dev_idx_t DEV_INVALID = 2'd3;
	localparam int DEV_COUNT = int'(DEV_INVALID) + 1;

	// Map sizes in bytes
	localparam logic [31:0] MAPSZ_DEVTBL = 32'h100;
	localparam logic [31:0] MAPSZ_INTCTRL = 32'h100;
	localparam logic [31:0] MAPSZ_RAM = 32'h400;
	localparam logic [31:0] MAPSZ_INVALID = 32'h1000;

	// Contiguous from zero, anything past the RAM is unmapped
	localparam logic [31:0] BASE_DEVTBL = 32'h0;
	localparam logic [31:0] BASE_INTCTRL = BASE_DEVTBL + MAPSZ_DEVTBL;
	localparam logic [31:0] BASE_RAM = BASE_INTCTRL + MAPSZ_INTCTRL;

	localparam logic [15:0] ID_DEVTBL = 16'd7;
	localparam logic [15:0] ID_INTCTRL = 16'd3;
	localparam logic [15:0] ID_RAM = 16'd1;
	localparam logic [15:0] ID_INVALID = 16'd0;
	localparam logic [DEV_COUNT-1:0] USEINTR = '0;

	// Interrupt sources
	localparam int INT_SRC_SDCARD = 0;
	localparam int INT_SRC_SERIAL = INT_SRC_SDCARD + 1;
	localparam int INT_SRC_COUNT = INT_SRC_SERIAL + 1;
	localparam int INT_IDX_W = $clog2(INT_SRC_COUNT);
	typedef logic [INT_SRC_COUNT-1:0] src_vec_t;
	typedef logic [INT_IDX_W-1:0] src_idx_t;

	// Word offsets inside the 256-byte register devices
	localparam int REG_WORD_W = 6;
	localparam logic [REG_WORD_W-1:0] RSTCTRL_WORD = 6'h3F;
	localparam logic [REG_WORD_W-1:0] INT_CUR_WORD = 6'h0;
	localparam logic [REG_WORD_W-1:0] INT_MASK_WORD = 6'h1;

	localparam int RAM_WORDS = int'(MAPSZ_RAM) / 4;
	localparam int RAM_WORD_W = $clog2(RAM_WORDS);

	localparam int RST_CNT_W = 8;
	localparam logic [RST_CNT_W-1:0] RST_HOLD = 8'd255;

endpackage

`default_nettype wire

// File: design/pi1_if.sv
`timescale 1ns/100ps
`default_nettype none

// One router-to-device link
interface pi1_if;

	pi1_pkg::op_t op;
	pi1_pkg::addr_t addr;
	pi1_pkg::data_t wdata;
	pi1_pkg::sel_t sel;
	pi1_pkg::data_t rdata;
	logic rdy;

	modport host (
		output op,
		output addr,
		output wdata,
		output sel,
		input  rdata,
		input  rdy
	);

	modport dev (
		input  op,
		input  addr,
		input  wdata,
		input  sel,
		output rdata,
		output rdy
	);

endinterface

`default_nettype wire

// File: design/rst_seq.sv
`timescale 1ns/100ps
`default_nettype none

module rst_seq (
	input  logic              clk24mhz,
	input  logic              rst_p,
	input  pi1_pkg::rst_req_t rst_req_i,
	input  logic              rst_req_vld_i,
	output logic              sys_rst_o,
	output logic              power_off_o
);

	logic [soc_map_pkg::RST_CNT_W-1:0] hold_cnt;
	logic restart;
	logic pwroff_req;
	logic pwroff_q;

	// Cold and warm requests both restart the hold
	assign restart = rst_req_vld_i &&
		((rst_req_i == pi1_pkg::RST_REQ_COLD) || (rst_req_i == pi1_pkg::RST_REQ_WARM));
	assign pwroff_req = rst_req_vld_i && (rst_req_i == pi1_pkg::RST_REQ_PWROFF);

	always_ff @(posedge clk24mhz) begin
		if (rst_p || restart) begin
			hold_cnt <= soc_map_pkg::RST_HOLD;
		end else if (hold_cnt != '0) begin
			hold_cnt <= hold_cnt - 1'b1;
		end
	end

	// Only the external reset brings the system back from power-off
	always_ff @(posedge clk24mhz) begin
		if (rst_p) begin
			pwroff_q <= 1'b0;
		end else if (pwroff_req) begin
			pwroff_q <= 1'b1;
		end
	end

	assign sys_rst_o = (hold_cnt != '0) || pwroff_q;
	assign power_off_o = pwroff_q;

endmodule

`default_nettype wire

// File: design/pi1_router.sv
`timescale 1ns/100ps
`default_nettype none

module pi1_router (
	input  logic           clk24mhz,
	input  logic           sys_rst_i,
	input  pi1_pkg::op_t   pi1_op_i,
	input  pi1_pkg::addr_t pi1_addr_i,
	input  pi1_pkg::data_t pi1_wdata_i,
	input  pi1_pkg::sel_t  pi1_sel_i,
	output pi1_pkg::data_t pi1_rdata_o,
	output logic           pi1_rdy_o,
	pi1_if.host            devtbl_o,
	pi1_if.host            intctrl_o,
	pi1_if.host            ram_o
);

	logic [pi1_pkg::DATA_W-1:0] byte_addr;
	soc_map_pkg::dev_idx_t sel_idx;
	soc_map_pkg::dev_idx_t rd_idx_q;
	pi1_pkg::op_t live_op;
	logic [soc_map_pkg::DEV_COUNT-1:0] dev_rdy;
	pi1_pkg::data_t dev_rdata [soc_map_pkg::DEV_COUNT];

	assign byte_addr = {pi1_addr_i, 2'b00};

	always_comb begin
		if (byte_addr < soc_map_pkg::BASE_INTCTRL) begin
			sel_idx = soc_map_pkg::DEV_DEVTBL;
		end else if (byte_addr < soc_map_pkg::BASE_RAM) begin
			sel_idx = soc_map_pkg::DEV_INTCTRL;
		end else if (byte_addr < soc_map_pkg::BASE_RAM + soc_map_pkg::MAPSZ_RAM) begin
			sel_idx = soc_map_pkg::DEV_RAM;
		end else begin
			sel_idx = soc_map_pkg::DEV_INVALID;
		end
	end

	// No request reaches a device while the system is held in reset
	assign live_op = sys_rst_i ? pi1_pkg::OP_NONE : pi1_op_i;

	// Devices see addresses relative to their own base
	assign devtbl_o.op = (sel_idx == soc_map_pkg::DEV_DEVTBL) ? live_op : pi1_pkg::OP_NONE;
	assign devtbl_o.addr = pi1_addr_i - pi1_pkg::addr_t'(soc_map_pkg::BASE_DEVTBL >> 2);
	assign devtbl_o.wdata = pi1_wdata_i;
	assign devtbl_o.sel = pi1_sel_i;

	assign intctrl_o.op = (sel_idx == soc_map_pkg::DEV_INTCTRL) ? live_op : pi1_pkg::OP_NONE;
	assign intctrl_o.addr = pi1_addr_i - pi1_pkg::addr_t'(soc_map_pkg::BASE_INTCTRL >> 2);
	assign intctrl_o.wdata = pi1_wdata_i;
	assign intctrl_o.sel = pi1_sel_i;

	assign ram_o.op = (sel_idx == soc_map_pkg::DEV_RAM) ? live_op : pi1_pkg::OP_NONE;
	assign ram_o.addr = pi1_addr_i - pi1_pkg::addr_t'(soc_map_pkg::BASE_RAM >> 2);
	assign ram_o.wdata = pi1_wdata_i;
	assign ram_o.sel = pi1_sel_i;

	// The catch-all device is always ready and reads as zero
	assign dev_rdy[soc_map_pkg::DEV_DEVTBL] = devtbl_o.rdy;
	assign dev_rdy[soc_map_pkg::DEV_INTCTRL] = intctrl_o.rdy;
	assign dev_rdy[soc_map_pkg::DEV_RAM] = ram_o.rdy;
	assign dev_rdy[soc_map_pkg::DEV_INVALID] = 1'b1;

	assign dev_rdata[soc_map_pkg::DEV_DEVTBL] = devtbl_o.rdata;
	assign dev_rdata[soc_map_pkg::DEV_INTCTRL] = intctrl_o.rdata;
	assign dev_rdata[soc_map_pkg::DEV_RAM] = ram_o.rdata;
	assign dev_rdata[soc_map_pkg::DEV_INVALID] = '0;

	assign pi1_rdy_o = !sys_rst_i && dev_rdy[sel_idx];

	// Remember which device answers the read in flight
	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			rd_idx_q <= soc_map_pkg::DEV_INVALID;
		end else if (pi1_rdy_o && pi1_pkg::op_reads(pi1_op_i)) begin
			rd_idx_q <= sel_idx;
		end
	end

	assign pi1_rdata_o = dev_rdata[rd_idx_q];

endmodule

`default_nettype wire

// File: design/dev_table.sv
`timescale 1ns/100ps
`default_nettype none

module dev_table (
	input  logic              clk24mhz,
	input  logic              sys_rst_i,
	pi1_if.dev                bus_i,
	output pi1_pkg::rst_req_t rst_req_o,
	output logic              rst_req_vld_o
);

	logic [soc_map_pkg::REG_WORD_W-1:0] word;
	logic rd_acc;
	logic wr_acc;
	logic rstctrl_wr;
	pi1_pkg::data_t rdata_q;

	// Even word holds id and interrupt use, odd word the map size
	function automatic pi1_pkg::data_t desc_word(input logic [soc_map_pkg::REG_WORD_W-1:0] w);
		soc_map_pkg::dev_idx_t idx;
		logic [15:0] id;
		pi1_pkg::data_t mapsz;
		idx = soc_map_pkg::dev_idx_t'(w >> 1);
		case (idx)
			soc_map_pkg::DEV_DEVTBL: begin
				id = soc_map_pkg::ID_DEVTBL;
				mapsz = soc_map_pkg::MAPSZ_DEVTBL;
			end
			soc_map_pkg::DEV_INTCTRL: begin
				id = soc_map_pkg::ID_INTCTRL;
				mapsz = soc_map_pkg::MAPSZ_INTCTRL;
			end
			soc_map_pkg::DEV_RAM: begin
				id = soc_map_pkg::ID_RAM;
				mapsz = soc_map_pkg::MAPSZ_RAM;
			end
			default: begin
				id = soc_map_pkg::ID_INVALID;
				mapsz = soc_map_pkg::MAPSZ_INVALID;
			end
		endcase
		if (32'(w) >= 2 * soc_map_pkg::DEV_COUNT) begin
			desc_word = '0;
		end else if (w[0]) begin
			desc_word = mapsz;
		end else begin
			desc_word = {15'b0, soc_map_pkg::USEINTR[idx], id};
		end
	endfunction

	assign word = bus_i.addr[soc_map_pkg::REG_WORD_W-1:0];
	assign bus_i.rdy = !sys_rst_i;
	assign rd_acc = bus_i.rdy && pi1_pkg::op_reads(bus_i.op);
	assign wr_acc = bus_i.rdy && pi1_pkg::op_writes(bus_i.op);
	assign rstctrl_wr = wr_acc && (word == soc_map_pkg::RSTCTRL_WORD) && bus_i.sel[0];

	always_ff @(posedge clk24mhz) begin
		if (rd_acc) begin
			rdata_q <= desc_word(word);
		end
	end

	assign bus_i.rdata = rdata_q;

	// Reset request lasts one cycle
	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			rst_req_o <= pi1_pkg::RST_REQ_NONE;
			rst_req_vld_o <= 1'b0;
		end else begin
			rst_req_vld_o <= rstctrl_wr;
			if (rstctrl_wr) begin
				rst_req_o <= bus_i.wdata[1:0];
			end
		end
	end

endmodule

`default_nettype wire

// File: design/int_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module int_ctrl (
	input  logic                  clk24mhz,
	input  logic                  sys_rst_i,
	pi1_if.dev                    bus_i,
	input  soc_map_pkg::src_vec_t intrqst_src_i,
	output soc_map_pkg::src_vec_t intrdy_src_o,
	output logic                  intrqst_dst_o,
	input  logic                  intrdy_dst_i
);

	logic [soc_map_pkg::REG_WORD_W-1:0] word;
	soc_map_pkg::src_vec_t req_prev_q;
	soc_map_pkg::src_vec_t pend_q;
	soc_map_pkg::src_vec_t mask_q;
	soc_map_pkg::src_vec_t enabled;
	soc_map_pkg::src_vec_t ack_vec;
	soc_map_pkg::src_idx_t best_idx;
	soc_map_pkg::src_idx_t cur_q;
	soc_map_pkg::src_idx_t last_q;
	logic ack;
	logic rd_acc;
	logic wr_acc;
	pi1_pkg::data_t rd_word;
	pi1_pkg::data_t rdata_q;

	assign enabled = pend_q & mask_q;
	assign ack = intrqst_dst_o && intrdy_dst_i;
	assign ack_vec = ack ? (soc_map_pkg::src_vec_t'(1) << cur_q) : '0;

	// Lowest index wins
	always_comb begin
		best_idx = '0;
		for (int i = soc_map_pkg::INT_SRC_COUNT - 1; i >= 0; i--) begin
			if (enabled[i]) begin
				best_idx = soc_map_pkg::src_idx_t'(i);
			end
		end
	end

	// Pending bits latch on a rising request, so a held line is served once
	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			req_prev_q <= '0;
			pend_q <= '0;
			intrdy_src_o <= '0;
			intrqst_dst_o <= 1'b0;
			cur_q <= '0;
			last_q <= '0;
		end else begin
			req_prev_q <= intrqst_src_i;
			pend_q <= (pend_q & ~ack_vec) | (intrqst_src_i & ~req_prev_q);
			intrdy_src_o <= ack_vec;
			if (ack) begin
				intrqst_dst_o <= 1'b0;
				last_q <= cur_q;
			end else if (!intrqst_dst_o && (enabled != '0)) begin
				intrqst_dst_o <= 1'b1;
				cur_q <= best_idx;
			end
		end
	end

	assign word = bus_i.addr[soc_map_pkg::REG_WORD_W-1:0];
	assign bus_i.rdy = !sys_rst_i;
	assign rd_acc = bus_i.rdy && pi1_pkg::op_reads(bus_i.op);
	assign wr_acc = bus_i.rdy && pi1_pkg::op_writes(bus_i.op);

	// All sources enabled out of reset
	always_ff @(posedge clk24mhz) begin
		if (sys_rst_i) begin
			mask_q <= '1;
		end else if (wr_acc && (word == soc_map_pkg::INT_MASK_WORD) && bus_i.sel[0]) begin
			mask_q <= bus_i.wdata[soc_map_pkg::INT_SRC_COUNT-1:0];
		end
	end

	always_comb begin
		rd_word = '0;
		if (word == soc_map_pkg::INT_CUR_WORD) begin
			rd_word = pi1_pkg::data_t'(last_q);
		end else if (word == soc_map_pkg::INT_MASK_WORD) begin
			rd_word = pi1_pkg::data_t'(mask_q);
		end
	end

	always_ff @(posedge clk24mhz) begin
		if (rd_acc) begin
			rdata_q <= rd_word;
		end
	end

	assign bus_i.rdata = rdata_q;

endmodule

`default_nettype wire

// File: design/scratch_ram.sv
`timescale 1ns/100ps
`default_nettype none

module scratch_ram (
	input  logic clk24mhz,
	pi1_if.dev   bus_i
);

	logic [soc_map_pkg::RAM_WORD_W-1:0] word;
	logic rd_acc;
	logic wr_acc;
	pi1_pkg::data_t rdata_q;
	pi1_pkg::data_t mem [soc_map_pkg::RAM_WORDS];

	assign word = bus_i.addr[soc_map_pkg::RAM_WORD_W-1:0];
	assign bus_i.rdy = 1'b1;
	assign rd_acc = pi1_pkg::op_reads(bus_i.op);
	assign wr_acc = pi1_pkg::op_writes(bus_i.op);

	// A read-write returns the word as it was before the merge
	always_ff @(posedge clk24mhz) begin
		if (rd_acc) begin
			rdata_q <= mem[word];
		end
		if (wr_acc) begin
			for (int b = 0; b < pi1_pkg::SEL_W; b++) begin
				if (bus_i.sel[b]) begin
					mem[word][8*b +: 8] <= bus_i.wdata[8*b +: 8];
				end
			end
		end
	end

	assign bus_i.rdata = rdata_q;

endmodule

`default_nettype wire

// File: design/soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module soc_top (
	input  logic                  clk24mhz,
	input  logic                  rst_p,
	input  pi1_pkg::op_t          pi1_op_i,
	input  pi1_pkg::addr_t        pi1_addr_i,
	input  pi1_pkg::data_t        pi1_wdata_i,
	input  pi1_pkg::sel_t         pi1_sel_i,
	output pi1_pkg::data_t        pi1_rdata_o,
	output logic                  pi1_rdy_o,
	input  soc_map_pkg::src_vec_t intrqst_src_i,
	output soc_map_pkg::src_vec_t intrdy_src_o,
	output logic                  intrqst_dst_o,
	input  logic                  intrdy_dst_i,
	output logic                  sys_rst_o,
	output logic                  power_off_o
);

	pi1_pkg::rst_req_t rst_req;
	logic rst_req_vld;

	pi1_if devtbl_bus ();
	pi1_if intctrl_bus ();
	pi1_if ram_bus ();

	rst_seq u_rst_seq (
		.clk24mhz      (clk24mhz),
		.rst_p         (rst_p),
		.rst_req_i     (rst_req),
		.rst_req_vld_i (rst_req_vld),
		.sys_rst_o     (sys_rst_o),
		.power_off_o   (power_off_o)
	);

	pi1_router u_router (
		.clk24mhz    (clk24mhz),
		.sys_rst_i   (sys_rst_o),
		.pi1_op_i    (pi1_op_i),
		.pi1_addr_i  (pi1_addr_i),
		.pi1_wdata_i (pi1_wdata_i),
		.pi1_sel_i   (pi1_sel_i),
		.pi1_rdata_o (pi1_rdata_o),
		.pi1_rdy_o   (pi1_rdy_o),
		.devtbl_o    (devtbl_bus.host),
		.intctrl_o   (intctrl_bus.host),
		.ram_o       (ram_bus.host)
	);

	dev_table u_dev_table (
		.clk24mhz      (clk24mhz),
		.sys_rst_i     (sys_rst_o),
		.bus_i         (devtbl_bus.dev),
		.rst_req_o     (rst_req),
		.rst_req_vld_o (rst_req_vld)
	);

	int_ctrl u_int_ctrl (
		.clk24mhz      (clk24mhz),
		.sys_rst_i     (sys_rst_o),
		.bus_i         (intctrl_bus.dev),
		.intrqst_src_i (intrqst_src_i),
		.intrdy_src_o  (intrdy_src_o),
		.intrqst_dst_o (intrqst_dst_o),
		.intrdy_dst_i  (intrdy_dst_i)
	);

	// RAM contents survive a software reset
	scratch_ram u_scratch_ram (
		.clk24mhz (clk24mhz),
		.bus_i    (ram_bus.dev)
	);

endmodule

`default_nettype wire

// File: tb/tb_soc_ref.svh
`ifndef TB_SOC_REF_SVH
`define TB_SOC_REF_SVH

// Expected descriptor word, devices listed in address map order
function automatic pi1_pkg::data_t desc_ref(input int w);
	logic [15:0] ids [soc_map_pkg::DEV_COUNT];
	logic [31:0] sizes [soc_map_pkg::DEV_COUNT];
	soc_map_pkg::dev_idx_t dev;
	ids = '{soc_map_pkg::ID_DEVTBL, soc_map_pkg::ID_INTCTRL, soc_map_pkg::ID_RAM,
		soc_map_pkg::ID_INVALID};
	sizes = '{soc_map_pkg::MAPSZ_DEVTBL, soc_map_pkg::MAPSZ_INTCTRL, soc_map_pkg::MAPSZ_RAM,
		soc_map_pkg::MAPSZ_INVALID};
	if (w >= 2 * soc_map_pkg::DEV_COUNT) begin
		return '0;
	end
	dev = soc_map_pkg::dev_idx_t'(w / 2);
	if (w % 2 == 1) begin
		return sizes[dev];
	end
	return {15'b0, soc_map_pkg::USEINTR[dev], ids[dev]};
endfunction

// Byte lanes with sel set take the new data
function automatic pi1_pkg::data_t ram_merge(input pi1_pkg::data_t old,
	input pi1_pkg::data_t wdata, input pi1_pkg::sel_t sel);
	pi1_pkg::data_t lane_mask;
	lane_mask = {{8{sel[3]}}, {8{sel[2]}}, {8{sel[1]}}, {8{sel[0]}}};
	return (old & ~lane_mask) | (wdata & lane_mask);
endfunction

// Lowest enabled pending source, -1 when nothing can be forwarded
function automatic int next_src(input soc_map_pkg::src_vec_t pend,
	input soc_map_pkg::src_vec_t mask);
	soc_map_pkg::src_vec_t live;
	live = pend & mask;
	for (int i = 0; i < soc_map_pkg::INT_SRC_COUNT; i++) begin
		if (live[i]) begin
			return i;
		end
	end
	return -1;
endfunction

function automatic pi1_pkg::data_t unmapped_ref();
	return '0;
endfunction

task automatic check_data(input pi1_pkg::data_t got, input pi1_pkg::data_t exp,
	input string msg);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("[ERROR] %0t: %s: got %h, expected %h", $time, msg, got, exp);
	end
endtask

task automatic check_src(input soc_map_pkg::src_vec_t got,
	input soc_map_pkg::src_vec_t exp, input string msg);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("[ERROR] %0t: %s: got %b, expected %b", $time, msg, got, exp);
	end
endtask

task automatic check_level(input logic got, input logic exp, input string msg);
	chk_cnt++;
	if (got !== exp) begin
		err_cnt++;
		$display("[ERROR] %0t: %s: got %b, expected %b", $time, msg, got, exp);
	end
endtask

`endif

// File: tb/tb_soc_top.sv
`timescale 1ns/100ps
`default_nettype none

module tb_soc_top;

	localparam int RST_HOLD_CYC = int'(soc_map_pkg::RST_HOLD);
	// Per-test budgets in cycles without the reset holds
	localparam int TEST_CYCLES = 30 + 160 + 60 + 100 + 60 + 60;
	localparam int CYCLE_LIMIT = (TEST_CYCLES + 4 * RST_HOLD_CYC) * 2;
	localparam int RAM_SLOTS = 16;
	localparam pi1_pkg::addr_t INT_W0 = pi1_pkg::addr_t'(soc_map_pkg::BASE_INTCTRL >> 2);
	localparam pi1_pkg::addr_t RAM_W0 = pi1_pkg::addr_t'(soc_map_pkg::BASE_RAM >> 2);
	localparam pi1_pkg::addr_t FREE_W0 =
		pi1_pkg::addr_t'((soc_map_pkg::BASE_RAM + soc_map_pkg::MAPSZ_RAM) >> 2);
	localparam pi1_pkg::addr_t CUR_ADDR = INT_W0 + pi1_pkg::addr_t'(soc_map_pkg::INT_CUR_WORD);
	localparam pi1_pkg::addr_t MASK_ADDR = INT_W0 + pi1_pkg::addr_t'(soc_map_pkg::INT_MASK_WORD);
	localparam pi1_pkg::addr_t RSTCTRL_ADDR = pi1_pkg::addr_t'(soc_map_pkg::RSTCTRL_WORD);

	logic clk24mhz;
	logic rst_p;
	pi1_pkg::op_t pi1_op_i;
	pi1_pkg::addr_t pi1_addr_i;
	pi1_pkg::data_t pi1_wdata_i;
	pi1_pkg::sel_t pi1_sel_i;
	pi1_pkg::data_t pi1_rdata_o;
	logic pi1_rdy_o;
	soc_map_pkg::src_vec_t intrqst_src_i;
	soc_map_pkg::src_vec_t intrdy_src_o;
	logic intrqst_dst_o;
	logic intrdy_dst_i;
	logic sys_rst_o;
	logic power_off_o;

	int err_cnt;
	int chk_cnt;
	int err_mark;
	int test_cnt;
	int fail_cnt;
	int cycle_cnt;
	int wait_cycles;
	integer seed;
	logic [31:0] rnd;
	pi1_pkg::data_t exp_q [$];
	string tag_q [$];
	pi1_pkg::data_t ram_model [256];
	logic [7:0] ram_slot [RAM_SLOTS];
	soc_map_pkg::src_vec_t irq_pend;
	soc_map_pkg::src_vec_t irq_mask;

	`include "tb_soc_ref.svh"

	soc_top uut (
		.clk24mhz      (clk24mhz),
		.rst_p         (rst_p),
		.pi1_op_i      (pi1_op_i),
		.pi1_addr_i    (pi1_addr_i),
		.pi1_wdata_i   (pi1_wdata_i),
		.pi1_sel_i     (pi1_sel_i),
		.pi1_rdata_o   (pi1_rdata_o),
		.pi1_rdy_o     (pi1_rdy_o),
		.intrqst_src_i (intrqst_src_i),
		.intrdy_src_o  (intrdy_src_o),
		.intrqst_dst_o (intrqst_dst_o),
		.intrdy_dst_i  (intrdy_dst_i),
		.sys_rst_o     (sys_rst_o),
		.power_off_o   (power_off_o)
	);

	initial begin
		clk24mhz = 1'b0;
		forever #10 clk24mhz = ~clk24mhz;
	end

	// Drive one request and return on the edge that accepts it
	task automatic issue(input pi1_pkg::op_t op, input pi1_pkg::addr_t addr,
		input pi1_pkg::data_t wdata, input pi1_pkg::sel_t sel,
		input pi1_pkg::data_t exp, input string tag);
		pi1_op_i <= op;
		pi1_addr_i <= addr;
		pi1_wdata_i <= wdata;
		pi1_sel_i <= sel;
		if (op == pi1_pkg::OP_READ || op == pi1_pkg::OP_RDWR) begin
			exp_q.push_back(exp);
			tag_q.push_back(tag);
		end
		wait_cycles = 0;
		do begin
			@(posedge clk24mhz);
			wait_cycles++;
		end while (pi1_rdy_o !== 1'b1);
	endtask

	task automatic write_word(input pi1_pkg::addr_t addr, input pi1_pkg::data_t wdata,
		input pi1_pkg::sel_t sel);
		issue(pi1_pkg::OP_WRITE, addr, wdata, sel, '0, "");
	endtask

	task automatic read_word(input pi1_pkg::addr_t addr, input pi1_pkg::data_t exp,
		input string tag);
		issue(pi1_pkg::OP_READ, addr, '0, '0, exp, tag);
	endtask

	task automatic bus_idle();
		pi1_op_i <= pi1_pkg::OP_NONE;
	endtask

	// Wait for the comparing process before reporting the test
	task automatic finish_test(input string name);
		int n;
		while (exp_q.size() != 0) @(negedge clk24mhz);
		@(posedge clk24mhz);
		n = err_cnt - err_mark;
		err_mark = err_cnt;
		test_cnt++;
		if (n != 0) begin
			fail_cnt++;
		end
		$display("test %0d %s: %s (%0d errors)", test_cnt, name, n == 0 ? "PASS" : "FAIL", n);
	endtask

	task automatic serve_irq();
		int idx;
		soc_map_pkg::src_vec_t expv;
		idx = next_src(irq_pend, irq_mask);
		expv = soc_map_pkg::src_vec_t'(1) << idx;
		while (intrqst_dst_o !== 1'b1) @(posedge clk24mhz);
		intrdy_dst_i <= 1'b1;
		@(posedge clk24mhz);
		intrdy_dst_i <= 1'b0;
		@(negedge clk24mhz);
		check_src(intrdy_src_o, expv, "acknowledge routed to source");
		irq_pend = irq_pend & ~expv;
		@(posedge clk24mhz);
		read_word(CUR_ADDR, pi1_pkg::data_t'(idx), "current source word");
		bus_idle();
	endtask

	task automatic test_ram();
		logic [7:0] slot;
		for (int k = 0; k < RAM_SLOTS; k++) begin
			rnd = $random(seed);
			ram_slot[k] = rnd[7:0];
		end
		// Full-word writes first so every byte of a slot is known
		for (int k = 0; k < RAM_SLOTS; k++) begin
			rnd = $random(seed);
			write_word(RAM_W0 + pi1_pkg::addr_t'(ram_slot[k]), rnd, 4'hF);
			ram_model[ram_slot[k]] = rnd;
		end
		for (int n = 0; n < 32; n++) begin
			rnd = $random(seed);
			slot = ram_slot[rnd[3:0]];
			rnd = $random(seed);
			ram_model[slot] = ram_merge(ram_model[slot], rnd, rnd[7:4]);
			write_word(RAM_W0 + pi1_pkg::addr_t'(slot), rnd, rnd[7:4]);
			read_word(RAM_W0 + pi1_pkg::addr_t'(slot), ram_model[slot],
				$sformatf("ram word %0d after merge", slot));
		end
		for (int k = 0; k < RAM_SLOTS; k++) begin
			read_word(RAM_W0 + pi1_pkg::addr_t'(ram_slot[k]), ram_model[ram_slot[k]],
				$sformatf("ram word %0d", ram_slot[k]));
		end
		bus_idle();
	endtask

	task automatic test_unmapped();
		read_word(FREE_W0, unmapped_ref(), "first unmapped word");
		check_level(wait_cycles == 1, 1'b1, "ready on unmapped read");
		rnd = $random(seed);
		read_word(pi1_pkg::addr_t'(rnd) | 30'h2000_0000, unmapped_ref(), "far unmapped word");
		check_level(wait_cycles == 1, 1'b1, "ready on far unmapped read");
		// These addresses would alias onto RAM slots if forwarded
		for (int k = 0; k < 4; k++) begin
			write_word(FREE_W0 + pi1_pkg::addr_t'(ram_slot[k]), ~ram_model[ram_slot[k]], 4'hF);
		end
		for (int k = 0; k < 4; k++) begin
			read_word(FREE_W0 + pi1_pkg::addr_t'(ram_slot[k]), unmapped_ref(),
				"unmapped after write");
			read_word(RAM_W0 + pi1_pkg::addr_t'(ram_slot[k]), ram_model[ram_slot[k]],
				"ram after unmapped write");
		end
		bus_idle();
	endtask

	task automatic test_interrupts();
		intrqst_src_i <= 2'b11;
		irq_pend = irq_pend | 2'b11;
		serve_irq();
		serve_irq();
		intrqst_src_i <= 2'b00;
		irq_mask = 2'b10;
		write_word(MASK_ADDR, pi1_pkg::data_t'(irq_mask), 4'hF);
		read_word(MASK_ADDR, pi1_pkg::data_t'(irq_mask), "mask readback");
		bus_idle();
		intrqst_src_i <= 2'b11;
		irq_pend = irq_pend | 2'b11;
		serve_irq();
		// Source 0 stays pending but masked
		repeat (4) @(posedge clk24mhz);
		check_level(intrqst_dst_o, 1'b0, "masked source not forwarded");
		intrqst_src_i <= 2'b00;
	endtask

	task automatic test_warm_reset();
		write_word(RSTCTRL_ADDR, pi1_pkg::data_t'(pi1_pkg::RST_REQ_WARM), 4'hF);
		bus_idle();
		while (sys_rst_o !== 1'b1) @(posedge clk24mhz);
		check_level(power_off_o, 1'b0, "no power-off on warm reset");
		while (sys_rst_o !== 1'b0) @(posedge clk24mhz);
		irq_mask = '1;
		irq_pend = '0;
		read_word(MASK_ADDR, pi1_pkg::data_t'(irq_mask), "mask after warm reset");
		for (int k = 0; k < RAM_SLOTS; k++) begin
			read_word(RAM_W0 + pi1_pkg::addr_t'(ram_slot[k]), ram_model[ram_slot[k]],
				"ram kept over warm reset");
		end
		bus_idle();
		// Source 0 was pending before the reset and the mask now enables it
		check_level(intrqst_dst_o, 1'b0, "no interrupt after warm reset");
	endtask

	task automatic test_power_off();
		write_word(RSTCTRL_ADDR, pi1_pkg::data_t'(pi1_pkg::RST_REQ_PWROFF), 4'hF);
		bus_idle();
		while (power_off_o !== 1'b1) @(posedge clk24mhz);
		// Stay off well past a full reset hold
		repeat (RST_HOLD_CYC + 8) @(posedge clk24mhz);
		check_level(sys_rst_o, 1'b1, "reset held in power-off");
		check_level(power_off_o, 1'b1, "power-off latched");
		check_level(pi1_rdy_o, 1'b0, "bus not ready in power-off");
		rst_p <= 1'b1;
		repeat (3) @(posedge clk24mhz);
		rst_p <= 1'b0;
		check_level(power_off_o, 1'b0, "power-off cleared by rst_p");
		while (sys_rst_o !== 1'b0) @(posedge clk24mhz);
		read_word('0, desc_ref(0), "descriptor after power cycle");
		bus_idle();
	endtask

	// Each accepted read is checked one cycle later
	initial begin
		forever begin
			@(posedge clk24mhz);
			if (pi1_rdy_o === 1'b1 &&
				(pi1_op_i == pi1_pkg::OP_READ || pi1_op_i == pi1_pkg::OP_RDWR)) begin
				@(negedge clk24mhz);
				if (exp_q.size() == 0) begin
					err_cnt++;
					$display("Read accepted at %0t with no expected value queued", $time);
				end else begin
					check_data(pi1_rdata_o, exp_q.pop_front(), tag_q.pop_front());
				end
			end
		end
	end

	initial begin
		cycle_cnt = 0;
		while (cycle_cnt <= CYCLE_LIMIT) begin
			@(posedge clk24mhz);
			cycle_cnt++;
		end
		$display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
		$display("tests failed");
		$finish;
	end

	initial begin
		seed = 32'h6895_d40a;
		err_cnt = 0;
		chk_cnt = 0;
		err_mark = 0;
		test_cnt = 0;
		fail_cnt = 0;
		irq_pend = '0;
		irq_mask = '1;
		rst_p = 1'b1;
		pi1_op_i = pi1_pkg::OP_NONE;
		pi1_addr_i = '0;
		pi1_wdata_i = '0;
		pi1_sel_i = '0;
		intrqst_src_i = '0;
		intrdy_dst_i = 1'b0;
		repeat (3) @(posedge clk24mhz);
		rst_p <= 1'b0;
		while (sys_rst_o !== 1'b0) @(posedge clk24mhz);
		for (int w = 0; w < 2 * soc_map_pkg::DEV_COUNT + 2; w++) begin
			read_word(pi1_pkg::addr_t'(w), desc_ref(w), $sformatf("descriptor word %0d", w));
		end
		bus_idle();
		finish_test("device table");
		test_ram();
		finish_test("scratch ram");
		test_unmapped();
		finish_test("unmapped addresses");
		test_interrupts();
		finish_test("interrupts");
		test_warm_reset();
		finish_test("warm reset");
		test_power_off();
		finish_test("power-off");
		$display("Summary: %0d tests, %0d failing, %0d checks, %0d errors",
			test_cnt, fail_cnt, chk_cnt, err_cnt);
		if (fail_cnt == 0 && err_cnt == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+tb
design/pi1_pkg.sv
design/soc_map_pkg.sv
design/pi1_if.sv
design/rst_seq.sv
design/pi1_router.sv
design/dev_table.sv
design/int_ctrl.sv
design/scratch_ram.sv
design/soc_top.sv
tb/tb_soc_top.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = tb_soc_top
FLIST    = flist.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = all tests passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)
